// File: logic/iso14443a_pkg.sv
// shared definitions for the ISO 14443-A receive path
// modified Miller sequence type, CRC_A constants, CRC_A byte update
`default_nettype none

package iso14443a_pkg;

    // classification of one bit period on the reader to card link
    typedef enum logic [1:0] {
        SEQ_X,
        SEQ_Y,
        SEQ_Z,
        SEQ_ERROR
    } pcd_bit_seq;

    // CRC_A preset, no final inversion
    localparam logic [15:0] CRC_A_INIT = 16'h6363;

    // x^16 + x^12 + x^5 + 1, bit reversed for lsb first shifting
    localparam logic [15:0] CRC_A_POLY_REFLECTED = 16'h8408;

    // fold one byte into a running CRC_A, lsb first
    function automatic logic [15:0] crc_a_byte(
        input logic [15:0] crc,
        input logic [7:0]  data
    );
        logic [15:0] c;
        c = crc ^ {8'h00, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_A_POLY_REFLECTED;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

`default_nettype wire

// File: logic/frame_rx_if.sv
// frame decoder output bundle
// source modport for the decoder, sink modport for consumers
`timescale 1ns/1ps
`default_nettype none

interface frame_rx_if;

    // start of communication, one cycle
    logic       soc;
    // end of communication, one cycle
    logic       eoc;
    // received byte, bit 0 is the first bit on air
    logic [7:0] data;
    // valid bits in data, 0 means a full byte
    logic [2:0] data_bits;
    // data and data_bits are valid this cycle
    logic       data_valid;
    // bad Miller sequence or empty frame
    logic       sequence_error;
    // odd parity mismatch or missing parity bit
    logic       parity_error;
    // value of the most recent bit, parity included
    logic       last_bit;

    modport source (
        output soc,
        output eoc,
        output data,
        output data_bits,
        output data_valid,
        output sequence_error,
        output parity_error,
        output last_bit
    );

    modport sink (
        input soc,
        input eoc,
        input data,
        input data_bits,
        input data_valid,
        input sequence_error,
        input parity_error,
        input last_bit
    );

endinterface

`default_nettype wire

// File: logic/sequence_decode.sv
// modified Miller sequence decoder
// synchronises pause_n, tracks bit periods, classifies each as X, Y, Z or error
`timescale 1ns/1ps
`default_nettype none

module sequence_decode
    import iso14443a_pkg::*;
#(
    parameter int BIT_TICKS = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pause_n,
    output pcd_bit_seq seq,
    output logic       seq_valid
);

    localparam int TW  = $clog2(BIT_TICKS);
    localparam int QTR = BIT_TICKS / 4;

    // quarter boundaries inside one period
    localparam logic [TW-1:0] Q1_END    = TW'(QTR);
    localparam logic [TW-1:0] Q2_END    = TW'(2 * QTR);
    localparam logic [TW-1:0] Q3_END    = TW'(3 * QTR);
    localparam logic [TW-1:0] LAST_TICK = TW'(BIT_TICKS - 1);

    // period must split into four equal quarters
    if (BIT_TICKS % 4 != 0 || BIT_TICKS < 4) begin : g_bad_ticks
        $error("BIT_TICKS must be a non-zero multiple of 4");
    end

    logic [1:0]    pause_sync;
    logic          pause_prev;
    logic          pause_fall;
    logic          active;
    logic [TW-1:0] tick;
    pcd_bit_seq    period_seq;
    pcd_bit_seq    period_seq_next;
    logic          y_seen;

    // two flop synchroniser, line idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pause_sync <= 2'b11;
            pause_prev <= 1'b1;
        end else begin
            pause_sync <= {pause_sync[0], pause_n};
            pause_prev <= pause_sync[1];
        end
    end

    // start of a pause
    assign pause_fall = pause_prev & ~pause_sync[1];

    // where did the pause land in this period
    // period_seq stays Y until an edge is seen
    always_comb begin
        period_seq_next = period_seq;
        if (pause_fall) begin
            if (period_seq != SEQ_Y) begin
                // second pause in one period
                period_seq_next = SEQ_ERROR;
            end else if (tick < Q1_END) begin
                period_seq_next = SEQ_Z;
            end else if (tick >= Q2_END && tick < Q3_END) begin
                period_seq_next = SEQ_X;
            end else begin
                period_seq_next = SEQ_ERROR;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active     <= 1'b0;
            tick       <= '0;
            period_seq <= SEQ_Y;
            y_seen     <= 1'b0;
            seq_valid  <= 1'b0;
        end else begin
            seq_valid <= 1'b0;
            if (!active) begin
                // first edge while idle is tick 0 of a Z period
                if (pause_fall) begin
                    active     <= 1'b1;
                    tick       <= TW'(1);
                    period_seq <= period_seq_next;
                end
            end else if (tick == LAST_TICK) begin
                // end of period, report it next cycle
                seq_valid  <= 1'b1;
                tick       <= '0;
                period_seq <= SEQ_Y;
                if (period_seq_next == SEQ_Y) begin
                    // two Y in a row means the line went quiet
                    y_seen <= ~y_seen;
                    if (y_seen) begin
                        active <= 1'b0;
                    end
                end else begin
                    y_seen <= 1'b0;
                end
            end else begin
                tick       <= tick + TW'(1);
                period_seq <= period_seq_next;
            end
        end
    end

    // sequence value, only meaningful with seq_valid
    always_ff @(posedge clk) begin
        if (active && tick == LAST_TICK) begin
            seq <= period_seq_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/frame_decode.sv
// frame decoder
// Miller sequences to SOC, EOC, data bytes, partial bytes and error strobes
`timescale 1ns/1ps
`default_nettype none

module frame_decode
    import iso14443a_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  pcd_bit_seq seq,
    input  logic       seq_valid,
    frame_rx_if.source rx
);

    logic       idle;
    // one period of delay, EOC is a 0 followed by Y
    pcd_bit_seq last_seq;
    logic       next_bit;
    // any bit seen since SOC
    logic       data_received;
    // eight data bits in, parity bit comes next
    logic       parity_due;
    logic       expected_parity;
    // hold off data until EOC
    logic       error_seen;
    logic [7:0] byte_q;
    logic [2:0] bit_cnt;

    // X carries a 1, Y and Z carry a 0
    assign next_bit = (last_seq == SEQ_X);

    // byte and its bit count go out as they stand
    assign rx.data      = byte_q;
    assign rx.data_bits = bit_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx.soc            <= 1'b0;
            rx.eoc            <= 1'b0;
            rx.data_valid     <= 1'b0;
            rx.sequence_error <= 1'b0;
            rx.parity_error   <= 1'b0;
            rx.last_bit       <= 1'b0;
            idle              <= 1'b1;
            last_seq          <= SEQ_Y;
            data_received     <= 1'b0;
            parity_due        <= 1'b0;
            expected_parity   <= 1'b1;
            error_seen        <= 1'b0;
            bit_cnt           <= '0;
        end else begin
            // strobes last one cycle
            rx.soc            <= 1'b0;
            rx.eoc            <= 1'b0;
            rx.data_valid     <= 1'b0;
            rx.sequence_error <= 1'b0;
            rx.parity_error   <= 1'b0;

            if (seq_valid) begin
                last_seq <= seq;

                if (idle) begin
                    // Y while idle is just the tail of the last frame
                    if (last_seq == SEQ_Z) begin
                        rx.soc          <= 1'b1;
                        idle            <= 1'b0;
                        data_received   <= 1'b0;
                        parity_due      <= 1'b0;
                        expected_parity <= 1'b1;
                        error_seen      <= 1'b0;
                        bit_cnt         <= '0;
                    end
                end else if (seq == SEQ_Y &&
                             (last_seq == SEQ_Y || last_seq == SEQ_Z)) begin
                    // logic 0 then Y, end of communication
                    rx.eoc <= 1'b1;
                    idle   <= 1'b1;
                    // full byte without its parity bit
                    if (parity_due) begin
                        rx.parity_error <= 1'b1;
                    end
                    // SOC straight into EOC
                    if (!data_received) begin
                        rx.sequence_error <= 1'b1;
                    end
                    // short last byte goes out with its bit count
                    if (!parity_due && data_received && !error_seen) begin
                        rx.data_valid <= (bit_cnt != 3'd0);
                    end
                end else if (!error_seen) begin
                    data_received <= 1'b1;
                    rx.last_bit   <= next_bit;

                    if (last_seq == SEQ_ERROR) begin
                        rx.sequence_error <= 1'b1;
                        error_seen        <= 1'b1;
                        // no parity complaint at EOC after this
                        parity_due        <= 1'b0;
                    end else if (parity_due) begin
                        parity_due <= 1'b0;
                        if (next_bit == expected_parity) begin
                            // byte accepted, bit_cnt wraps to 0 for full byte
                            rx.data_valid   <= 1'b1;
                            expected_parity <= 1'b1;
                        end else begin
                            rx.parity_error <= 1'b1;
                            error_seen      <= 1'b1;
                        end
                    end else begin
                        // odd parity, each 1 flips the expected bit
                        if (next_bit) begin
                            expected_parity <= ~expected_parity;
                        end
                        if (bit_cnt == 3'd7) begin
                            parity_due <= 1'b1;
                        end
                        bit_cnt <= bit_cnt + 3'd1;
                    end
                end
            end
        end
    end

    // byte assembly, first bit clears the stale upper bits
    always_ff @(posedge clk) begin
        if (seq_valid && !idle && !error_seen && !parity_due &&
            last_seq != SEQ_ERROR &&
            !(seq == SEQ_Y && (last_seq == SEQ_Y || last_seq == SEQ_Z))) begin
            if (bit_cnt == 3'd0) begin
                byte_q <= {7'd0, next_bit};
            end else begin
                byte_q[bit_cnt] <= next_bit;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/crc_a_check.sv
// CRC_A checker
// accumulates over full bytes, reports frame_done and crc_ok after EOC
`timescale 1ns/1ps
`default_nettype none

module crc_a_check
    import iso14443a_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    frame_rx_if.sink rx,
    output logic     frame_done,
    output logic     crc_ok
);

    logic [15:0] crc;
    // saturates at 3, one data byte plus two CRC bytes minimum
    logic [1:0]  byte_cnt;
    // partial byte or error strobe earlier in the frame
    logic        frame_bad;
    logic        partial_now;
    logic        error_now;

    // EOC can carry a short byte or an error strobe in the same cycle
    assign partial_now = rx.data_valid && (rx.data_bits != 3'd0);
    assign error_now   = rx.sequence_error || rx.parity_error;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc        <= CRC_A_INIT;
            byte_cnt   <= '0;
            frame_bad  <= 1'b0;
            frame_done <= 1'b0;
            crc_ok     <= 1'b0;
        end else begin
            frame_done <= rx.eoc;
            // residue is zero once the appended CRC is folded in
            crc_ok     <= rx.eoc && (crc == 16'h0000) && (byte_cnt == 2'd3) &&
                          !frame_bad && !partial_now && !error_now;

            if (rx.soc) begin
                crc       <= CRC_A_INIT;
                byte_cnt  <= '0;
                frame_bad <= 1'b0;
            end else begin
                if (rx.data_valid && rx.data_bits == 3'd0) begin
                    crc <= crc_a_byte(crc, rx.data);
                    if (byte_cnt != 2'd3) begin
                        byte_cnt <= byte_cnt + 2'd1;
                    end
                end
                if (partial_now || error_now) begin
                    frame_bad <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/iso14443a_rx.sv
// ISO 14443-A reader to card receive path, top level
// sequence decoder, frame decoder and CRC_A checker wired to plain ports
`timescale 1ns/1ps
`default_nettype none

module iso14443a_rx
    import iso14443a_pkg::*;
#(
    parameter int BIT_TICKS = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    // low during a reader pause
    input  logic       pause_n,
    output logic       soc,
    output logic [7:0] rx_data,
    output logic [2:0] rx_bits,
    output logic       rx_valid,
    output logic       sequence_error,
    output logic       parity_error,
    output logic       last_bit,
    output logic       frame_done,
    output logic       crc_ok
);

    pcd_bit_seq seq;
    logic       seq_valid;

    frame_rx_if rx_if ();

    // pause waveform to one sequence per bit period
    sequence_decode #(
        .BIT_TICKS (BIT_TICKS)
    ) u_sequence_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .pause_n   (pause_n),
        .seq       (seq),
        .seq_valid (seq_valid)
    );

    frame_decode u_frame_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .seq       (seq),
        .seq_valid (seq_valid),
        .rx        (rx_if.source)
    );

    crc_a_check u_crc_a_check (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx         (rx_if.sink),
        .frame_done (frame_done),
        .crc_ok     (crc_ok)
    );

    // frame decoder outputs straight to the pins
    assign soc            = rx_if.soc;
    assign rx_data        = rx_if.data;
    assign rx_bits        = rx_if.data_bits;
    assign rx_valid       = rx_if.data_valid;
    assign sequence_error = rx_if.sequence_error;
    assign parity_error   = rx_if.parity_error;
    assign last_bit       = rx_if.last_bit;

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
// clock and reset generator for the testbench
// 4 ns clock, reset held low for the first 3 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 250 MHz free running clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // release just after a rising edge, in step with the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tests/iso14443a_rx_asserts.sv
// concurrent checks on the receive path outputs, bound into the top level
// strobe width, rx_valid against parity_error, no data outside a frame
`timescale 1ns/1ps
`default_nettype none

module iso14443a_rx_asserts (
    input logic clk,
    input logic rst_n,
    input logic soc,
    input logic rx_valid,
    input logic parity_error,
    input logic frame_done
);

    // number of failed assertions, read by the testbench at the end
    int failures = 0;
    // high from frame_done until the next soc
    logic after_frame;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            after_frame <= 1'b0;
        end else if (soc) begin
            after_frame <= 1'b0;
        end else if (frame_done) begin
            after_frame <= 1'b1;
        end
    end

    soc_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        soc |=> !soc)
    else begin
        $error("soc held high for more than one cycle");
        failures++;
    end

    frame_done_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        frame_done |=> !frame_done)
    else begin
        $error("frame_done held high for more than one cycle");
        failures++;
    end

    // a rejected byte is never delivered
    valid_not_with_parity_error: assert property (@(posedge clk) disable iff (!rst_n)
        !(rx_valid && parity_error))
    else begin
        $error("rx_valid together with parity_error");
        failures++;
    end

    no_data_between_frames: assert property (@(posedge clk) disable iff (!rst_n)
        (frame_done || after_frame) |-> !rx_valid)
    else begin
        $error("rx_valid between frame_done and the next soc");
        failures++;
    end

endmodule

bind iso14443a_rx iso14443a_rx_asserts rx_asserts_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .soc          (soc),
    .rx_valid     (rx_valid),
    .parity_error (parity_error),
    .frame_done   (frame_done)
);

`default_nettype wire

// File: tests/iso14443a_rx_tb.sv
// testbench for the ISO 14443-A receive path
// modified Miller encoder, reference model, response checker and test sequence
`timescale 1ns/1ps
`default_nettype none

module iso14443a_rx_tb
    import iso14443a_pkg::*;
();

    localparam int BIT_TICKS = 16;
    localparam int QTR       = BIT_TICKS / 4;
    // worst frame: SOC, 8 bytes with parity, 7 trailing bits, EOC,
    // frame_done wait and idle gap, 26 frames plus the idle test
    localparam int TOTAL_BITS  = 26 * 93 + 4;
    localparam int CYCLE_LIMIT = 3 * TOTAL_BITS * BIT_TICKS;

    // corruption applied to a frame
    localparam int CORRUPT_NONE   = 0;
    localparam int CORRUPT_PARITY = 1;
    localparam int CORRUPT_PAUSE  = 2;

    logic       clk;
    logic       rst_n;
    logic       pause_n;
    logic       soc;
    logic [7:0] rx_data;
    logic [2:0] rx_bits;
    logic       rx_valid;
    logic       sequence_error;
    logic       parity_error;
    logic       last_bit;
    logic       frame_done;
    logic       crc_ok;

    // frame under test
    logic [7:0] frame_bytes[$];
    int         trail_bits;
    logic [7:0] trail_val;
    int         corrupt_kind;
    int         corrupt_idx;

    // encoded line, one sequence per bit period
    pcd_bit_seq line_q[$];
    // last bit sent was a 1, so a 0 goes out as Y
    logic       prev_one;

    // expected bytes as {rx_bits, rx_data}
    logic [10:0] exp_q[$];
    int          exp_seq_err;
    int          exp_par_err;
    logic        exp_crc_ok;

    int   got_soc;
    int   got_seq_err;
    int   got_par_err;
    logic frame_seen;
    int   errors = 0;
    int   tests = 0;
    int   failed = 0;
    int   cycles = 0;

    tb_clock clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    iso14443a_rx #(
        .BIT_TICKS (BIT_TICKS)
    ) iso14443a_rx_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .pause_n        (pause_n),
        .soc            (soc),
        .rx_data        (rx_data),
        .rx_bits        (rx_bits),
        .rx_valid       (rx_valid),
        .sequence_error (sequence_error),
        .parity_error   (parity_error),
        .last_bit       (last_bit),
        .frame_done     (frame_done),
        .crc_ok         (crc_ok)
    );

    // 1 is X, 0 is Y after a 1 and Z otherwise
    function automatic void push_bit(input logic b);
        if (b) begin
            line_q.push_back(SEQ_X);
        end else if (prev_one) begin
            line_q.push_back(SEQ_Y);
        end else begin
            line_q.push_back(SEQ_Z);
        end
        prev_one = b;
    endfunction

    function automatic void build_line();
        logic par;
        line_q.delete();
        // SOC is Z, a 0 right after it is Z too
        line_q.push_back(SEQ_Z);
        prev_one = 1'b0;
        foreach (frame_bytes[i]) begin
            // misplaced pause gets a period of its own before the byte
            if (corrupt_kind == CORRUPT_PAUSE && i == corrupt_idx) begin
                line_q.push_back(SEQ_ERROR);
                prev_one = 1'b1;
            end
            for (int j = 0; j < 8; j++) begin
                push_bit(frame_bytes[i][j]);
            end
            // odd parity over the byte
            par = ~^frame_bytes[i];
            if (corrupt_kind == CORRUPT_PARITY && i == corrupt_idx) begin
                par = ~par;
            end
            push_bit(par);
        end
        for (int j = 0; j < trail_bits; j++) begin
            push_bit(trail_val[j]);
        end
        // EOC, a logic 0 then Y
        push_bit(1'b0);
        line_q.push_back(SEQ_Y);
    endfunction

    // pause_n level at one tick of a period
    function automatic logic line_level(input pcd_bit_seq s, input int t);
        case (s)
            SEQ_Z:     return !(t < QTR);
            SEQ_X:     return !(t >= 2 * QTR && t < 3 * QTR);
            // pause at the end of the first quarter, neither Z nor X
            SEQ_ERROR: return !(t >= QTR && t < 2 * QTR);
            default:   return 1'b1;
        endcase
    endfunction

    task automatic send_line();
        foreach (line_q[i]) begin
            for (int t = 0; t < BIT_TICKS; t++) begin
                @(posedge clk);
                #1;
                pause_n = line_level(line_q[i], t);
            end
        end
        @(posedge clk);
        #1;
        pause_n = 1'b1;
    endtask

    // reference model, fills exp_q and the error counts, returns crc_ok
    function automatic logic expected_frame();
        logic [15:0] crc;
        logic [7:0]  mask;
        exp_q.delete();
        exp_seq_err = 0;
        exp_par_err = 0;
        crc = CRC_A_INIT;
        // SOC straight into EOC carries no data
        if (frame_bytes.size() == 0 && trail_bits == 0) begin
            exp_seq_err = 1;
            return 1'b0;
        end
        foreach (frame_bytes[i]) begin
            // data stops at the corrupted byte
            if (corrupt_kind == CORRUPT_PARITY && i == corrupt_idx) begin
                exp_par_err = 1;
                return 1'b0;
            end
            if (corrupt_kind == CORRUPT_PAUSE && i == corrupt_idx) begin
                exp_seq_err = 1;
                return 1'b0;
            end
            exp_q.push_back({3'd0, frame_bytes[i]});
            crc = crc_a_byte(crc, frame_bytes[i]);
        end
        // a short last byte spoils the CRC
        if (trail_bits != 0) begin
            mask = 8'((1 << trail_bits) - 1);
            exp_q.push_back({3'(trail_bits), trail_val & mask});
            return 1'b0;
        end
        // CRC bytes folded in leave a zero residue
        return (frame_bytes.size() >= 3) && (crc == 16'h0000);
    endfunction

    // CRC_A goes out low byte first
    function automatic void append_crc();
        logic [15:0] crc;
        crc = CRC_A_INIT;
        foreach (frame_bytes[i]) begin
            crc = crc_a_byte(crc, frame_bytes[i]);
        end
        frame_bytes.push_back(crc[7:0]);
        frame_bytes.push_back(crc[15:8]);
    endfunction

    function automatic void new_frame(input int n);
        frame_bytes.delete();
        trail_bits   = 0;
        trail_val    = 8'h00;
        corrupt_kind = CORRUPT_NONE;
        corrupt_idx  = 0;
        repeat (n) begin
            frame_bytes.push_back(8'($urandom));
        end
    endfunction

    task automatic finish_test(input string name, input int start_errors);
        tests++;
        if (errors == start_errors) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed++;
            $display("test %0d %s: FAILED, %0d errors", tests, name, errors - start_errors);
        end
    endtask

    task automatic run_frame(input string name);
        int start_errors;
        int waited;
        start_errors = errors;
        exp_crc_ok   = expected_frame();
        got_soc      = 0;
        got_seq_err  = 0;
        got_par_err  = 0;
        frame_seen   = 1'b0;
        build_line();
        send_line();
        waited = 0;
        while (!frame_seen && waited < 8 * BIT_TICKS) begin
            @(posedge clk);
            waited++;
        end
        if (!frame_seen) begin
            $display("ERROR at %0t: frame_done did not arrive after the frame", $time);
            errors++;
        end
        // give the sequence decoder time to drop back to idle
        repeat (3 * BIT_TICKS) @(posedge clk);
        finish_test(name, start_errors);
    endtask

    task automatic check_byte();
        logic [10:0] exp;
        if (exp_q.size() == 0) begin
            $display("ERROR at %0t: rx_valid with no byte expected, rx_data %02h",
                     $time, rx_data);
            errors++;
        end else begin
            exp = exp_q.pop_front();
            if (rx_data !== exp[7:0]) begin
                $display("MISMATCH at %0t: rx_data expected %02h, got %02h",
                         $time, exp[7:0], rx_data);
                errors++;
            end
            if (rx_bits !== exp[10:8]) begin
                $display("MISMATCH at %0t: rx_bits expected %0d, got %0d",
                         $time, exp[10:8], rx_bits);
                errors++;
            end
        end
    endtask

    task automatic check_frame_end();
        if (crc_ok !== exp_crc_ok) begin
            $display("MISMATCH at %0t: crc_ok expected %b, got %b", $time, exp_crc_ok, crc_ok);
            errors++;
        end
        if (got_soc != 1) begin
            $display("MISMATCH at %0t: soc count expected 1, got %0d", $time, got_soc);
            errors++;
        end
        if (got_seq_err != exp_seq_err) begin
            $display("MISMATCH at %0t: sequence_error count expected %0d, got %0d",
                     $time, exp_seq_err, got_seq_err);
            errors++;
        end
        if (got_par_err != exp_par_err) begin
            $display("MISMATCH at %0t: parity_error count expected %0d, got %0d",
                     $time, exp_par_err, got_par_err);
            errors++;
        end
        if (exp_q.size() != 0) begin
            $display("ERROR at %0t: %0d expected bytes never arrived", $time, exp_q.size());
            errors++;
        end
        frame_seen = 1'b1;
    endtask

    // outputs are sampled half a cycle after they change
    always @(negedge clk) begin
        if (rst_n) begin
            if (soc) got_soc++;
            if (sequence_error) got_seq_err++;
            if (parity_error) got_par_err++;
            if (rx_valid) check_byte();
            if (frame_done) check_frame_end();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        int          start;
        logic [15:0] crc;
        pause_n = 1'b1;
        void'($urandom(48));
        @(posedge rst_n);

        // known CRC_A values from the standard
        start = errors;
        crc = crc_a_byte(crc_a_byte(CRC_A_INIT, 8'h00), 8'h00);
        if (crc !== 16'h1ea0) begin
            $display("MISMATCH at %0t: crc_a(00 00) expected 1ea0, got %04h", $time, crc);
            errors++;
        end
        crc = crc_a_byte(crc_a_byte(CRC_A_INIT, 8'h12), 8'h34);
        if (crc !== 16'hcf26) begin
            $display("MISMATCH at %0t: crc_a(12 34) expected cf26, got %04h", $time, crc);
            errors++;
        end
        finish_test("CRC_A reference values", start);

        // quiet line after reset
        start = errors;
        repeat (4 * BIT_TICKS) begin
            @(negedge clk);
            if ({soc, rx_valid, sequence_error, parity_error, last_bit, frame_done, crc_ok}
                !== 7'd0) begin
                $display("MISMATCH at %0t: soc..crc_ok expected 0000000, got %b", $time,
                         {soc, rx_valid, sequence_error, parity_error, last_bit,
                          frame_done, crc_ok});
                errors++;
            end
        end
        finish_test("idle after reset", start);

        new_frame(3);
        append_crc();
        run_frame("three bytes with CRC_A");
        // same frame, one payload byte flipped
        frame_bytes[1] = frame_bytes[1] ^ 8'h5a;
        run_frame("corrupted payload byte");

        new_frame(0);
        trail_bits = 7;
        trail_val  = 8'h26;
        run_frame("short frame 26h");

        new_frame(3);
        corrupt_kind = CORRUPT_PARITY;
        corrupt_idx  = 1;
        run_frame("inverted parity on byte 2");

        new_frame(3);
        corrupt_kind = CORRUPT_PAUSE;
        corrupt_idx  = 1;
        run_frame("misplaced pause");
        new_frame(0);
        run_frame("SOC then EOC");

        for (int f = 1; f <= 20; f++) begin
            new_frame(1 + int'($urandom % 6));
            if (f % 2 == 0) begin
                append_crc();
            end else begin
                trail_bits = int'($urandom % 8);
                trail_val  = 8'($urandom);
            end
            run_frame($sformatf("random frame %0d", f));
        end

        errors += iso14443a_rx_inst.rx_asserts_inst.failures;
        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
logic/iso14443a_pkg.sv
logic/frame_rx_if.sv
logic/sequence_decode.sv
logic/frame_decode.sv
logic/crc_a_check.sv
logic/iso14443a_rx.sv
tests/tb_clock.sv
tests/iso14443a_rx_asserts.sv
tests/iso14443a_rx_tb.sv

// File: Makefile
TOP = iso14443a_rx_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timescale 1ns/1ps -f sources.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir
